//--- mipsCore.f
src/mipsIsaPkg.sv
src/cpuCtrlPkg.sv
src/unifiedMemory.sv
src/registerFile.sv
src/aluUnit.sv
src/controlFsm.sv
src/datapath.sv
src/mipsCore.sv
testbench/mipsCoreTb.sv

//--- runSim.sh
#!/bin/sh
# Compile the testbench and core with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module mipsCoreTb \
    -f mipsCore.f \
    -o mipsCoreSim

# Nonzero exit on any failing run
./obj_dir/mipsCoreSim

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb
    import mipsIsaPkg::*, cpuCtrlPkg::*;
;
    localparam logic [31:0] resetPc = 32'd128;
    localparam int tailCycles = 8;           // Quiet cycles checked after last store

    // Instructions per program, test 5 runs its program three times
    localparam int rTypeLen   = 19;
    localparam int addiLen    = 11;
    localparam int branchLen  = 18;
    localparam int jumpLen    = 13;
    localparam int runCtrlLen = 5;
    localparam int totalInstr = rTypeLen + addiLen + branchLen + jumpLen + 3 * runCtrlLen;
    localparam int cycleLimit = totalInstr * 5 + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        run;
    hostLoad_t   hostIn;
    storeEvent_t storeOut;

    logic [31:0] prog[$];                    // Program words, loaded at resetPc
    storeEvent_t expStores[$];
    int          firstStoreCycle;            // Cycles from run rise to first store
    logic [31:0] lfsrState = 32'd78;
    int          runCycles = 0;

    always #4 clk = ~clk;

    mipsCore #(.memWords(1024), .resetPc(resetPc)) u_mipsCore (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .hostIn   (hostIn),
        .storeOut (storeOut)
    );

    ////////////////////////////////////////
    // Failure handling and checks
    ////////////////////////////////////////

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkStore(input storeEvent_t got, input storeEvent_t expected);
        if (got !== expected)
        begin
            $display("ERR @%0t: store to %h data %h, expected store to %h data %h",
                     $time, got.addr, got.data, expected.addr, expected.data);
            abortRun();
        end
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
        if (got !== expected)
        begin
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, expected);
            abortRun();
        end
    endtask

    // Stores only while running
    always @(negedge clk)
    begin
        if (storeOut.valid && (reset || !run))
        begin
            $display("A store strobe appeared while the core was held in reset or stopped");
            abortRun();
        end
    end

    // Watchdog on running cycles
    always @(posedge clk)
    begin
        if (run)
            runCycles <= runCycles + 1;
        if (runCycles > cycleLimit)
        begin
            $display("Timeout: core ran %0d cycles without finishing the tests", runCycles);
            abortRun();
        end
    end

    ////////////////////////////////////////
    // Assembler and stimulus helpers
    ////////////////////////////////////////

    function automatic instr_t rType(input funct_t fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt);
        return instr_t'({opRType, rs, rt, rd, 5'd0, fn});
    endfunction

    // Operand order as in assembly, "op rt, imm(rs)"
    function automatic instr_t iType(input opcode_t op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
        return instr_t'({op, rs, rt, imm});
    endfunction

    function automatic instr_t jType(input opcode_t op, input logic [31:0] byteAddr);
        return instr_t'({op, byteAddr[27:2]});   // Word target, top PC bits kept
    endfunction

    function automatic logic [31:0] progAddr(input int idx);
        return resetPc + 32'(4 * idx);
    endfunction

    function automatic logic [31:0] signExt16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        repeat (n)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};  // One step per bit
        end
    endtask

    task automatic emit(input instr_t i);
        prog.push_back(i);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        storeEvent_t ev;
        ev.valid = 1'b1;
        ev.addr  = addr;
        ev.data  = data;
        expStores.push_back(ev);
    endtask

    // Offset counted in words from PC+4
    task automatic branchTo(input logic [4:0] rs, input logic [4:0] rt, input int targetIdx);
        int offset;
        offset = targetIdx - (prog.size() + 1);
        emit(iType(opBeq, rt, rs, 16'(offset)));
    endtask

    task automatic emitHalt();
        branchTo(5'd0, 5'd0, prog.size());    // Spin on itself
    endtask

    task automatic clearProgram();
        prog.delete();
        expStores.delete();
    endtask

    // Called at the drive point, one strobe cycle
    task automatic loadWord(input logic [31:0] addr, input logic [31:0] data);
        hostIn.valid = 1'b1;
        hostIn.addr  = addr;
        hostIn.data  = data;
        @(posedge clk);
        #1;
        hostIn.valid = 1'b0;
    endtask

    task automatic loadProgram();
        foreach (prog[i])
            loadWord(progAddr(i), prog[i]);
    endtask

    task automatic pulseReset();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    ////////////////////////////////////////
    // Run the loaded program, check stores
    ////////////////////////////////////////

    task automatic runProgram();
        int idx;
        int cyc;
        idx = 0;
        cyc = -1;
        firstStoreCycle = -1;
        run = 1'b1;
        while (idx < expStores.size())
        begin
            @(negedge clk);                   // Mid-cycle sample
            cyc++;                            // Cycle 0 is the one run rises in
            if (storeOut.valid)
            begin
                checkStore(storeOut, expStores[idx]);
                if (idx == 0)
                    firstStoreCycle = cyc;
                idx++;
            end
        end
        repeat (tailCycles)
        begin
            @(negedge clk);
            if (storeOut.valid)
            begin
                $display("Unexpected extra store to %h after the last expected one",
                         storeOut.addr);
                abortRun();
            end
        end
        @(posedge clk);
        #1;
        run = 1'b0;
        @(posedge clk);                       // FSM back in idle
        #1;
    endtask

    task automatic aluStoreStep(input funct_t fn, input logic [4:0] rd, input logic [4:0] rs,
                                input logic [4:0] rt, input logic [31:0] addr,
                                input logic [31:0] result);
        emit(rType(fn, rd, rs, rt));
        emit(iType(opSw, rd, 5'd0, addr[15:0]));
        expectStore(addr, result);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic testRType();
        logic [31:0] opA;
        logic [31:0] opB;
        clearProgram();
        takeBits(32, opA);
        takeBits(32, opB);
        loadWord(32'h0, opA);
        loadWord(32'h4, opB);
        emit(iType(opLw, 5'd1, 5'd0, 16'h0000));
        emit(iType(opLw, 5'd2, 5'd0, 16'h0004));
        aluStoreStep(fnAdd, 5'd3, 5'd1, 5'd2, 32'h40, opA + opB);
        aluStoreStep(fnSub, 5'd4, 5'd1, 5'd2, 32'h44, opA - opB);
        aluStoreStep(fnAnd, 5'd5, 5'd1, 5'd2, 32'h48, opA & opB);
        aluStoreStep(fnOr,  5'd6, 5'd1, 5'd2, 32'h4C, opA | opB);
        aluStoreStep(fnXor, 5'd7, 5'd1, 5'd2, 32'h50, opA ^ opB);
        aluStoreStep(fnSlt, 5'd8, 5'd1, 5'd2, 32'h54,
                     ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
        aluStoreStep(fnSlt, 5'd10, 5'd2, 5'd1, 32'h58,
                     ($signed(opB) < $signed(opA)) ? 32'd1 : 32'd0);
        emit(iType(opLw, 5'd9, 5'd0, 16'h0040));  // Read back stored sum
        emit(iType(opSw, 5'd9, 5'd0, 16'h005C));
        expectStore(32'h5C, opA + opB);
        emitHalt();
        loadProgram();
        runProgram();
    endtask

    task automatic testAddi();
        clearProgram();
        emit(iType(opAddi, 5'd4, 5'd0, 16'h1234));
        emit(iType(opSw, 5'd4, 5'd0, 16'h0040));
        expectStore(32'h40, signExt16(16'h1234));
        emit(iType(opAddi, 5'd5, 5'd4, 16'hFFF0));  // Minus 16
        emit(iType(opSw, 5'd5, 5'd0, 16'h0044));
        expectStore(32'h44, signExt16(16'h1234) + signExt16(16'hFFF0));
        emit(iType(opAddi, 5'd6, 5'd0, 16'h8000));
        emit(iType(opSw, 5'd6, 5'd0, 16'h0048));
        expectStore(32'h48, signExt16(16'h8000));
        emit(iType(opAddi, 5'd0, 5'd4, 16'h0005));  // r0 write dropped
        emit(iType(opSw, 5'd0, 5'd0, 16'h004C));
        expectStore(32'h4C, 32'd0);
        emit(iType(opAddi, 5'd7, 5'd0, 16'h0060));
        emit(iType(opSw, 5'd5, 5'd7, 16'hFFFC));    // Negative address offset
        expectStore(32'h60 + signExt16(16'hFFFC), signExt16(16'h1234) + signExt16(16'hFFF0));
        emitHalt();
        loadProgram();
        runProgram();
    endtask

    task automatic testBranch();
        clearProgram();
        emit(iType(opAddi, 5'd1, 5'd0, 16'd7));
        emit(iType(opAddi, 5'd2, 5'd0, 16'd7));
        emit(iType(opAddi, 5'd3, 5'd0, 16'd9));
        emit(iType(opAddi, 5'd10, 5'd0, 16'h00AA));  // Taken-path marker
        emit(iType(opAddi, 5'd11, 5'd0, 16'h00BB));
        branchTo(5'd1, 5'd2, 8);                     // Taken, skips two
        emit(iType(opSw, 5'd11, 5'd0, 16'h0040));
        emit(iType(opSw, 5'd11, 5'd0, 16'h0040));
        emit(iType(opSw, 5'd10, 5'd0, 16'h0040));
        branchTo(5'd1, 5'd3, 11);                    // Not taken
        emit(iType(opSw, 5'd11, 5'd0, 16'h0044));
        emit(iType(opSw, 5'd10, 5'd0, 16'h0048));
        expectStore(32'h40, 32'h0000_00AA);
        expectStore(32'h44, 32'h0000_00BB);
        expectStore(32'h48, 32'h0000_00AA);
        // Countdown loop, backward branch
        emit(iType(opAddi, 5'd12, 5'd0, 16'd2));
        emit(iType(opAddi, 5'd12, 5'd12, 16'hFFFF));
        emit(iType(opSw, 5'd12, 5'd0, 16'h004C));
        branchTo(5'd12, 5'd0, 17);
        branchTo(5'd0, 5'd0, 13);
        expectStore(32'h4C, 32'd1);
        expectStore(32'h4C, 32'd0);
        emitHalt();
        loadProgram();
        runProgram();
    endtask

    task automatic testJumps();
        clearProgram();
        emit(iType(opAddi, 5'd20, 5'd0, 16'h0011));
        emit(iType(opAddi, 5'd21, 5'd0, 16'h00EE));  // Never stored
        emit(iType(opAddi, 5'd22, 5'd0, 16'h0022));
        emit(jType(opJ, progAddr(5)));
        emit(iType(opSw, 5'd21, 5'd0, 16'h0040));
        emit(iType(opSw, 5'd20, 5'd0, 16'h0040));
        emit(jType(opJal, progAddr(10)));            // Index 6
        emit(iType(opSw, 5'd22, 5'd0, 16'h0048));    // Return point
        emitHalt();
        emit(iType(opSw, 5'd21, 5'd0, 16'h004C));
        emit(iType(opSw, 5'd31, 5'd0, 16'h0044));    // Subroutine, link value
        emit(rType(fnJr, 5'd0, 5'd31, 5'd0));
        emit(iType(opSw, 5'd21, 5'd0, 16'h004C));
        expectStore(32'h40, 32'h0000_0011);
        expectStore(32'h44, progAddr(6) + 32'd4);
        expectStore(32'h48, 32'h0000_0022);
        loadProgram();
        runProgram();
    endtask

    task automatic testRunControl();
        logic [31:0] dataA;
        logic [31:0] dataB;
        int          storeCycle;
        clearProgram();
        // First fetch one cycle after run, then lw, addi and the sw store cycle
        storeCycle = 1 + 5 + 4 + 4 - 1;
        takeBits(32, dataA);
        takeBits(32, dataB);
        loadWord(32'h10, dataA);
        emit(iType(opLw, 5'd1, 5'd0, 16'h0010));
        emit(iType(opAddi, 5'd2, 5'd1, 16'd1));
        emit(iType(opSw, 5'd2, 5'd0, 16'h0050));
        emit(iType(opSw, 5'd1, 5'd0, 16'h0054));
        emitHalt();
        expectStore(32'h50, dataA + 32'd1);
        expectStore(32'h54, dataA);
        loadProgram();
        runProgram();
        checkWord(32'(firstStoreCycle), 32'(storeCycle), "cycles from run to first store");
        runProgram();                         // Restarts from resetPc
        checkWord(32'(firstStoreCycle), 32'(storeCycle), "rerun cycles to first store");
        // Reset while stopped, then new data word
        pulseReset();
        loadWord(32'h10, dataB);
        expStores.delete();
        expectStore(32'h50, dataB + 32'd1);
        expectStore(32'h54, dataB);
        runProgram();
        checkWord(32'(firstStoreCycle), 32'(storeCycle), "cycles to first store after reset");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        reset  = 1'b1;
        run    = 1'b0;
        hostIn = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        testRType();
        testAddi();
        testBranch();
        testJumps();
        testRunControl();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import mipsIsaPkg::*, cpuCtrlPkg::*;
#(
    parameter int          memWords = 1024,
    parameter logic [31:0] resetPc  = 32'd128
)
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      run,
    input  wire hostLoad_t hostIn,
    output storeEvent_t    storeOut
);
    ctrl_t       ctrl;        // FSM to datapath
    instr_t      instr;       // IR back to FSM
    logic        zero;
    logic [31:0] memAddr, memWdata, memRdata;

    ////////////////////////////////////////
    // Control, datapath, memory
    ////////////////////////////////////////

    controlFsm u_controlFsm (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .instr (instr),
        .ctrl  (ctrl)
    );

    datapath #(.resetPc(resetPc)) u_datapath (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .storeOut (storeOut),
        .instr    (instr),
        .zero     (zero)
    );

    unifiedMemory #(.memWords(memWords)) u_unifiedMemory (
        .clk    (clk),
        .hostIn (hostIn),
        .run    (run),
        .addr   (memAddr),
        .wdata  (memWdata),
        .we     (ctrl.memWrite),
        .rdata  (memRdata)
    );

endmodule

`default_nettype wire

//--- src/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import mipsIsaPkg::*, cpuCtrlPkg::*;
#(
    parameter logic [31:0] resetPc = 32'd128
)
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        run,
    input  wire ctrl_t       ctrl,
    input  wire logic [31:0] memRdata,
    output logic [31:0]      memAddr,
    output logic [31:0]      memWdata,
    output storeEvent_t      storeOut,
    output instr_t           instr,
    output logic             zero
);
    logic [31:0] pc, pcNext;
    logic        pcEn;
    logic [31:0] mdr, regA, regB, aluOut;
    logic [31:0] rfRdataA, rfRdataB, rfWdata;
    logic [4:0]  rfWaddr;
    logic [31:0] aluA, aluB, aluResult;
    logic [31:0] immExt, jumpTarget;

    ////////////////////////////////////////
    // Architectural and latch registers
    ////////////////////////////////////////

    assign pcEn = ctrl.pcWrite | (ctrl.pcWriteCond & zero);   // beq taken

    always_ff @(posedge clk)
    begin
        if (reset || !run)
            pc <= resetPc;                    // Rearmed for every run
        else if (pcEn)
            pc <= pcNext;
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.irWrite)
            instr <= instr_t'(memRdata);
        mdr    <= memRdata;                   // Used by lw writeback
        regA   <= rfRdataA;
        regB   <= rfRdataB;
        aluOut <= aluResult;
    end

    // Sign extended immediate and jump target
    assign immExt     = {{16{instr[15]}}, instr[15:0]};
    assign jumpTarget = {pc[31:28], instr[25:0], 2'b00};

    ////////////////////////////////////////
    // Multiplexers
    ////////////////////////////////////////

    assign memAddr  = ctrl.iOrD ? aluOut : pc;
    assign memWdata = regB;                   // sw data is rt
    assign aluA     = ctrl.aluSrcA ? regA : pc;

    always_comb
    begin
        case (ctrl.aluSrcB)
            srcBFour:     aluB = 32'd4;
            srcBImm:      aluB = immExt;
            srcBImmShift: aluB = {immExt[29:0], 2'b00};  // Word offset
            default:      aluB = regB;
        endcase
        case (ctrl.regDst)
            dstRd:   rfWaddr = instr.rd;
            dstRa:   rfWaddr = 5'd31;         // Link register
            default: rfWaddr = instr.rt;
        endcase
        case (ctrl.memToReg)
            wbMdr:   rfWdata = mdr;
            wbPc:    rfWdata = pc;            // Already PC + 4
            default: rfWdata = aluOut;
        endcase
        case (ctrl.pcSource)
            pcAluOut:     pcNext = aluOut;
            pcJumpTarget: pcNext = jumpTarget;
            pcRegA:       pcNext = regA;
            default:      pcNext = aluResult;
        endcase
    end

    // Store report, same cycle as the memory write
    assign storeOut.valid = ctrl.memWrite;
    assign storeOut.addr  = memAddr;
    assign storeOut.data  = memWdata;

    registerFile u_registerFile (
        .clk    (clk),
        .reset  (reset),
        .raddrA (instr.rs),
        .raddrB (instr.rt),
        .waddr  (rfWaddr),
        .wdata  (rfWdata),
        .we     (ctrl.regWrite),
        .rdataA (rfRdataA),
        .rdataB (rfRdataB)
    );

    aluUnit u_aluUnit (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

endmodule

`default_nettype wire

//--- src/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm
    import mipsIsaPkg::*, cpuCtrlPkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   run,
    input  wire instr_t instr,
    output ctrl_t       ctrl
);
    cpuState_t state;
    cpuState_t stateNext;
    logic      functLegal;
    aluOp_t    rTypeOp;

    // R-type functions handled by execute
    assign functLegal = instr.funct inside {fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt};

    always_comb
    begin
        case (instr.funct)
            fnSub:   rTypeOp = aluSub;
            fnAnd:   rTypeOp = aluAnd;
            fnOr:    rTypeOp = aluOr;
            fnXor:   rTypeOp = aluXor;
            fnSlt:   rTypeOp = aluSlt;
            default: rTypeOp = aluAdd;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= stIdle;
        else
            state <= stateNext;
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb
    begin
        stateNext = stFetch;                  // Single-step states end here
        if (!run)
            stateNext = stIdle;               // Abandon anything in flight
        else
        begin
            case (state)
                stFetch:   stateNext = stDecode;
                stDecode:
                begin
                    case (instr.opcode)
                        opRType:
                        begin
                            if (instr.funct == fnJr)
                                stateNext = stJumpReg;
                            else if (functLegal)
                                stateNext = stExecute;
                        end
                        opLw, opSw: stateNext = stMemAddr;
                        opBeq:      stateNext = stBranch;
                        opAddi:     stateNext = stExecute;
                        opJ:        stateNext = stJump;
                        opJal:      stateNext = stJumpLink;
                        default:    stateNext = stFetch;  // Illegal, no writes
                    endcase
                end
                stMemAddr: stateNext = (instr.opcode == opLw) ? stMemRead : stMemWrite;
                stMemRead: stateNext = stMemWriteback;
                stExecute: stateNext = stAluWriteback;
                default:   stateNext = stFetch;
            endcase
        end
    end

    ////////////////////////////////////////
    // Control word per state
    ////////////////////////////////////////

    always_comb
    begin
        ctrl = '0;                            // Idle and all writes off
        if (run)
        begin
            case (state)
                stFetch:
                begin
                    ctrl.irWrite  = 1'b1;
                    ctrl.pcWrite  = 1'b1;     // PC <= PC + 4
                    ctrl.aluSrcB  = srcBFour;
                end
                stDecode:       ctrl.aluSrcB = srcBImmShift;   // Branch target into ALUOut
                stMemAddr:
                begin
                    ctrl.aluSrcA = 1'b1;
                    ctrl.aluSrcB = srcBImm;
                end
                stMemRead:      ctrl.iOrD = 1'b1;
                stMemWriteback:
                begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = wbMdr;
                end
                stMemWrite:
                begin
                    ctrl.iOrD     = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
                stExecute:
                begin
                    ctrl.aluSrcA = 1'b1;
                    ctrl.aluSrcB = (instr.opcode == opAddi) ? srcBImm : srcBReg;
                    ctrl.aluOp   = (instr.opcode == opAddi) ? aluAdd : rTypeOp;
                end
                stAluWriteback:
                begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst   = (instr.opcode == opRType) ? dstRd : dstRt;
                end
                stBranch:
                begin
                    ctrl.aluSrcA     = 1'b1;
                    ctrl.aluOp       = aluSub;    // Zero when rs == rt
                    ctrl.pcWriteCond = 1'b1;
                    ctrl.pcSource    = pcAluOut;
                end
                stJump:
                begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = pcJumpTarget;
                end
                stJumpLink:
                begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = pcJumpTarget;
                    ctrl.regWrite = 1'b1;         // r31 <= jal address + 4
                    ctrl.regDst   = dstRa;
                    ctrl.memToReg = wbPc;
                end
                stJumpReg:
                begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = pcRegA;
                end
                default:        ctrl = '0;
            endcase
        end
    end

    // Encoding has spare codes, none may ever be reached
    stateLegal: assert property (@(posedge clk) disable iff (reset)
        state inside {stIdle, stFetch, stDecode, stMemAddr, stMemRead, stMemWriteback,
                      stMemWrite, stExecute, stAluWriteback, stBranch, stJump,
                      stJumpLink, stJumpReg})
        else $error("FSM in undefined state");

endmodule

`default_nettype wire

//--- src/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import mipsIsaPkg::*;
(
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    input  wire aluOp_t      op,
    output logic [31:0]      result,
    output logic             zero
);
    logic aLessB;

    // Two's complement compare for slt
    assign aLessB = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            aluAdd:  result = a + b;          // Also PC+4 and address calc
            aluSub:  result = a - b;          // beq compare
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {31'd0, aLessB};
            default: result = 32'd0;
        endcase
    end

    // Branch equality flag
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  raddrA,
    input  wire logic [4:0]  raddrB,
    input  wire logic [4:0]  waddr,
    input  wire logic [31:0] wdata,
    input  wire logic        we,
    output logic [31:0]      rdataA,
    output logic [31:0]      rdataB
);
    logic [31:0] regs [32];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;                // Whole file starts clean
        end
        else if (we && waddr != 5'd0)
            regs[waddr] <= wdata;             // r0 stays hardwired
    end

    ////////////////////////////////////////
    // Read ports, combinational
    ////////////////////////////////////////

    // r0 forced to zero on both ports
    assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

`default_nettype wire

//--- src/unifiedMemory.sv
`timescale 1ns/1ps
`default_nettype none

module unifiedMemory
    import cpuCtrlPkg::*;
#(
    parameter int memWords = 1024   // Power of two
)
(
    input  wire logic        clk,
    input  wire hostLoad_t   hostIn,
    input  wire logic        run,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wdata,
    input  wire logic        we,
    output logic [31:0]      rdata
);
    localparam int idxBits = $clog2(memWords);

    logic [31:0]        mem [memWords];   // Instructions and data together
    logic [idxBits-1:0] coreIdx;
    logic [idxBits-1:0] hostIdx;

    // Byte addresses, word index above bit 1
    assign coreIdx = addr[idxBits+1:2];
    assign hostIdx = hostIn.addr[idxBits+1:2];

    // Single write port, owner chosen by run
    always_ff @(posedge clk)
    begin
        if (run)
        begin
            if (we)
                mem[coreIdx] <= wdata;        // Core store
        end
        else if (hostIn.valid)
            mem[hostIdx] <= hostIn.data;      // Program/data load
    end

    assign rdata = mem[coreIdx];              // Combinational read

    // Host loads are only legal while the core is stopped
    hostOnlyStopped: assert property (@(posedge clk) run |-> !hostIn.valid)
        else $error("host load dropped, core is running");

    // FSM must not leave a store pending once run drops
    coreOnlyRunning: assert property (@(posedge clk) !run |-> !we)
        else $error("core write while stopped");

endmodule

`default_nettype wire

//--- src/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;
    import mipsIsaPkg::*;

    ////////////////////////////////////////
    // Multicycle FSM states
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        stIdle, stFetch, stDecode,
        stMemAddr, stMemRead, stMemWriteback, stMemWrite,
        stExecute, stAluWriteback,
        stBranch, stJump, stJumpLink, stJumpReg
    } cpuState_t;

    // Mux select encodings
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDst_t;
    typedef enum logic [1:0] {wbAluOut, wbMdr, wbPc} memToReg_t;
    typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBImmShift} aluSrcB_t;
    typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJumpTarget, pcRegA} pcSource_t;

    ////////////////////////////////////////
    // Control word, FSM to datapath
    ////////////////////////////////////////

    typedef struct packed {
        logic      pcWrite;     // Unconditional PC load
        logic      pcWriteCond; // PC load when ALU zero
        logic      iOrD;        // 0 PC, 1 ALUOut as memory address
        logic      memWrite;
        logic      irWrite;
        regDst_t   regDst;
        memToReg_t memToReg;
        logic      regWrite;
        logic      aluSrcA;     // 0 PC, 1 register A
        aluSrcB_t  aluSrcB;
        aluOp_t    aluOp;
        pcSource_t pcSource;
    } ctrl_t;

    // Host program/data load strobe
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } hostLoad_t;

    // One store seen on the core write port
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } storeEvent_t;

endpackage

`default_nettype wire

//--- src/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    ////////////////////////////////////////
    // Opcode and funct encodings
    ////////////////////////////////////////

    typedef enum logic [5:0] {
        opRType = 6'h00,    // Operation chosen by funct
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        fnJr  = 6'h08,      // Jump through rs
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2A       // Signed compare
    } funct_t;

    // Field view of an instruction word
    // Immediate is bits [15:0], i.e. {rd, shamt, funct}
    // Jump target is bits [25:0], i.e. {rs, rt, rd, shamt, funct}
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_t;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt
    } aluOp_t;

endpackage

`default_nettype wire
